//--- Makefile
# Verilator lint and simulation of the softmax unit
TOP = tb_softmax_vec
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f softmax_vec.f --top-module softmax_vec

sim:
	verilator --binary --timing --assert -Wno-fatal -f softmax_vec.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- exp_unit.sv
/*
 * Per-lane offset subtraction and base-2 exponent approximation for one tile
 */
`timescale 1ns/1ps
`include "softmax_defs.svh"

module exp_unit import softmax_pkg::*; (
    input  logic [`SOFTMAX_TILE_W-1:0]  rd_tile,
    input  q16_word_t                   max_val,
    input  q16_word_t                   ln_sum,
    input  logic                        use_ln,
    output logic [`SOFTMAX_TILE_W-1:0]  exp_tile
);

    localparam int W    = `SOFTMAX_WIDTH;
    localparam int FRAC = `SOFTMAX_FRAC;
    localparam int TILE = `SOFTMAX_TILE;
    localparam logic signed [W-1:0] LOG2E = `SOFTMAX_LOG2E_Q;
    // Below -32.0 every shift empties the mantissa
    localparam int SAT_LO = -(32 << `SOFTMAX_FRAC);

    logic signed [W-1:0] ln_off;

    // Second pass also removes ln(sum)
    assign ln_off = use_ln ? $signed(ln_sum.raw) : '0;

    for (genvar g = 0; g < TILE; g++) begin : g_lane
        logic signed [W-1:0]   x_lane;
        logic signed [W+1:0]   diff;
        logic signed [2*W+1:0] prod;
        logic signed [2*W+1:0] scaled;
        q16_word_t             word;
        logic [5:0]            shamt;
        logic [W-1:0]          mant;

        assign x_lane = $signed(rd_tile[(TILE-1-g)*W +: W]);

        // Two extra bits keep x - max - ln from wrapping
        assign diff = x_lane - $signed(max_val.raw) - ln_off;

        // e^d = 2^(d * log2 e)
        assign prod   = diff * LOG2E;
        assign scaled = prod >>> FRAC;

        always_comb begin
            if (scaled < SAT_LO) begin
                word.raw = SAT_LO;
            end else begin
                word.raw = scaled[W-1:0];
            end
        end

        // Integer part sets the shift and the fraction gives 1 + f
        assign shamt = 6'(-word.fields.int_part);
        assign mant  = {{(W-FRAC-1){1'b0}}, 1'b1, word.fields.frac};

        assign exp_tile[(TILE-1-g)*W +: W] = (shamt >= 6'd32) ? '0 : (mant >> shamt);
    end

endmodule

//--- ln_unit.sv
/*
 * Natural log of the exp sum from its leading-one position, registered on load
 */
`timescale 1ns/1ps
`include "softmax_defs.svh"

module ln_unit import softmax_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ln_load,
    input  logic [`SOFTMAX_SUM_W-1:0]   sum_exp,
    output q16_word_t                   ln_sum
);

    localparam int W      = `SOFTMAX_WIDTH;
    localparam int FRAC   = `SOFTMAX_FRAC;
    localparam int INT_W  = `SOFTMAX_WIDTH - `SOFTMAX_FRAC;
    localparam int SUM_W  = `SOFTMAX_SUM_W;
    localparam int LEAD_W = $clog2(`SOFTMAX_SUM_W);
    localparam logic signed [W-1:0] LN2 = `SOFTMAX_LN2_Q;

    logic [LEAD_W-1:0]     lead;
    logic [SUM_W-1:0]      norm;
    q16_word_t             log2_word;
    logic signed [2*W-1:0] ln_prod;

    // Highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < SUM_W; i++) begin
            if (sum_exp[i]) begin
                lead = LEAD_W'(i);
            end
        end
    end

    // Leading one moved to the top, the bits under it become the fraction
    assign norm = sum_exp << (SUM_W - 1 - int'(lead));

    // log2(sum) ~ (p - 16) + mantissa bits
    always_comb begin
        log2_word.fields.int_part = INT_W'(int'(lead) - FRAC);
        log2_word.fields.frac     = norm[SUM_W-2 -: FRAC];
    end

    // ln = log2 * ln2, rescaled back to Q16.16
    assign ln_prod = $signed(log2_word.raw) * LN2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ln_sum.raw <= '0;
        end else if (ln_load) begin
            ln_sum.raw <= ln_prod[FRAC +: W];
        end
    end

endmodule

//--- max_tracker.sv
/*
 * Running signed maximum over the accepted input tiles
 */
`timescale 1ns/1ps
`include "softmax_defs.svh"

module max_tracker import softmax_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        max_clear,
    input  logic                        max_en,
    input  logic [`SOFTMAX_TILE_W-1:0]  x_tile,
    output q16_word_t                   max_val
);

    localparam int W    = `SOFTMAX_WIDTH;
    localparam int TILE = `SOFTMAX_TILE;
    localparam logic signed [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};

    logic signed [W-1:0] tile_max;
    logic signed [W-1:0] lane;

    // Largest lane of this tile, element 0 sits in the top chunk
    always_comb begin
        tile_max = $signed(x_tile[TILE*W-1 -: W]);
        lane     = tile_max;
        for (int i = 1; i < TILE; i++) begin
            lane = $signed(x_tile[(TILE-1-i)*W +: W]);
            if (lane > tile_max) begin
                tile_max = lane;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || max_clear) begin
            max_val.raw <= MOST_NEG;
        end else if (max_en && (tile_max > $signed(max_val.raw))) begin
            max_val.raw <= tile_max;
        end
    end

endmodule

//--- softmax_ctrl.sv
/*
 * Phase FSM, tile counters and buffer addresses
 * Also holds the output tile register and the done pulse
 */
`timescale 1ns/1ps
`include "softmax_defs.svh"

module softmax_ctrl import softmax_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        tile_in_valid,
    input  logic [`SOFTMAX_TILE_W-1:0]  exp_tile,
    output logic                        wr_en,
    output logic [`SOFTMAX_ADDR_W-1:0]  wr_addr,
    output logic [`SOFTMAX_ADDR_W-1:0]  rd_addr,
    output logic                        max_clear,
    output logic                        max_en,
    output logic                        use_ln,
    output logic                        sum_clear,
    output logic                        sum_en,
    output logic                        ln_load,
    output logic [`SOFTMAX_TILE_W-1:0]  y_tile,
    output logic                        tile_out_valid,
    output logic                        done
);

    localparam int LAST = `SOFTMAX_TILES - 1;

    softmax_state_t state;
    softmax_state_t state_next;

    logic launch;
    logic wr_last;
    logic rd_run;
    logic rd_last;
    logic pass2_rd_d;
    logic out_load;
    logic drained;

    // Start only counts between runs
    assign launch  = start && ((state == S_IDLE) || (state == S_DONE));
    // Tiles outside the load phase are dropped
    assign wr_en   = tile_in_valid && (state == S_LOAD);
    assign wr_last = wr_en && (int'(wr_addr) == LAST);
    assign rd_last = rd_run && (int'(rd_addr) == LAST);

    assign max_clear = launch;
    assign max_en    = wr_en;
    assign sum_clear = launch;
    assign use_ln    = (state == S_PASS2);
    assign ln_load   = (state == S_LN);

    // RAM data of a pass-two read is ready one cycle later
    assign out_load = pass2_rd_d;
    // Last output tile is on the port and nothing follows
    assign drained  = tile_out_valid && !out_load;

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE:   if (launch) state_next = S_LOAD;
            S_LOAD:   if (wr_last) state_next = S_PASS1;
            S_PASS1:  if (rd_last) state_next = S_DRAIN1;
            S_DRAIN1: state_next = S_LN;
            S_LN:     state_next = S_PASS2;
            S_PASS2:  if (drained) state_next = S_DONE;
            S_DONE:   state_next = launch ? S_LOAD : S_IDLE;
            default:  state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            wr_addr <= '0;
            rd_addr <= '0;
            rd_run  <= 1'b0;
        end else begin
            state <= state_next;

            // Write address doubles as the loaded tile count
            if (launch || wr_last) begin
                wr_addr <= '0;
            end else if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
            end

            // Read sweep for either pass, one tile per cycle
            if (wr_last || (state == S_LN)) begin
                rd_run  <= 1'b1;
                rd_addr <= '0;
            end else if (rd_last) begin
                rd_run  <= 1'b0;
                rd_addr <= '0;
            end else if (rd_run) begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // Read strobes delayed to line up with RAM output
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_en     <= 1'b0;
            pass2_rd_d <= 1'b0;
        end else begin
            sum_en     <= rd_run && (state == S_PASS1);
            pass2_rd_d <= rd_run && (state == S_PASS2);
        end
    end

    // Output tile register and end-of-run pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            y_tile         <= '0;
            tile_out_valid <= 1'b0;
            done           <= 1'b0;
        end else begin
            if (out_load) begin
                y_tile <= exp_tile;
            end
            tile_out_valid <= out_load;
            done           <= (state == S_PASS2) && drained;
        end
    end

endmodule

//--- softmax_defs.svh
/*
 * Word format, tile geometry and fixed-point constants for the softmax datapath
 */
`ifndef SOFTMAX_DEFS_SVH
`define SOFTMAX_DEFS_SVH

// Q16.16 element format
`define SOFTMAX_WIDTH 32
`define SOFTMAX_FRAC 16

// Vector geometry, element count must be a whole number of tiles
`define SOFTMAX_TILE 4
`define SOFTMAX_ELEMS 32
`define SOFTMAX_TILES (`SOFTMAX_ELEMS / `SOFTMAX_TILE)
`define SOFTMAX_ADDR_W ($clog2(`SOFTMAX_TILES))

// Exp sum grows by log2 of the element count
`define SOFTMAX_SUM_W (`SOFTMAX_WIDTH + $clog2(`SOFTMAX_ELEMS + 1))
`define SOFTMAX_TILE_W (`SOFTMAX_WIDTH * `SOFTMAX_TILE)

// ln(2) and log2(e) in Q16.16
`define SOFTMAX_LN2_Q 32'h0000_B172
`define SOFTMAX_LOG2E_Q 32'h0001_7154

`endif

//--- softmax_pkg.sv
/*
 * Shared types: Q16.16 word with integer/fraction view, controller states
 */
`include "softmax_defs.svh"

package softmax_pkg;

    // One Q16.16 word, seen whole or split at the binary point
    typedef union packed {
        logic signed [`SOFTMAX_WIDTH-1:0] raw;
        struct packed {
            logic signed [`SOFTMAX_WIDTH-`SOFTMAX_FRAC-1:0] int_part;
            logic [`SOFTMAX_FRAC-1:0]                       frac;
        } fields;
    } q16_word_t;

    // Phases of one softmax run
    typedef enum logic [2:0] {
        S_IDLE   = 3'd0,
        S_LOAD   = 3'd1,
        S_PASS1  = 3'd2,
        S_DRAIN1 = 3'd3,
        S_LN     = 3'd4,
        S_PASS2  = 3'd5,
        S_DONE   = 3'd6
    } softmax_state_t;

endpackage

//--- softmax_vec.f
+incdir+.
softmax_pkg.sv
tile_buffer.sv
max_tracker.sv
exp_unit.sv
sum_accumulator.sv
ln_unit.sv
softmax_ctrl.sv
softmax_vec.sv
tb_softmax_vec.sv

//--- softmax_vec.sv
/*
 * Two-pass streaming softmax top, controller plus datapath wiring
 */
`timescale 1ns/1ps
`include "softmax_defs.svh"

module softmax_vec import softmax_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [`SOFTMAX_TILE_W-1:0]  x_tile,
    input  logic                        tile_in_valid,
    output logic [`SOFTMAX_TILE_W-1:0]  y_tile,
    output logic                        tile_out_valid,
    output logic                        done
);

    // Buffer control
    logic                       wr_en;
    logic [`SOFTMAX_ADDR_W-1:0] wr_addr;
    logic [`SOFTMAX_ADDR_W-1:0] rd_addr;
    logic [`SOFTMAX_TILE_W-1:0] rd_tile;

    // Datapath control
    logic max_clear;
    logic max_en;
    logic use_ln;
    logic sum_clear;
    logic sum_en;
    logic ln_load;

    // Datapath results
    q16_word_t                  max_val;
    q16_word_t                  ln_sum;
    logic [`SOFTMAX_TILE_W-1:0] exp_tile;
    logic [`SOFTMAX_SUM_W-1:0]  sum_exp;

    softmax_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .tile_in_valid  (tile_in_valid),
        .exp_tile       (exp_tile),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .rd_addr        (rd_addr),
        .max_clear      (max_clear),
        .max_en         (max_en),
        .use_ln         (use_ln),
        .sum_clear      (sum_clear),
        .sum_en         (sum_en),
        .ln_load        (ln_load),
        .y_tile         (y_tile),
        .tile_out_valid (tile_out_valid),
        .done           (done)
    );

    // Input tiles are kept for the replay in pass two
    tile_buffer u_tile_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_tile (x_tile),
        .rd_addr (rd_addr),
        .rd_tile (rd_tile)
    );

    max_tracker u_max_tracker (
        .clk       (clk),
        .rst_n     (rst_n),
        .max_clear (max_clear),
        .max_en    (max_en),
        .x_tile    (x_tile),
        .max_val   (max_val)
    );

    exp_unit u_exp_unit (
        .rd_tile  (rd_tile),
        .max_val  (max_val),
        .ln_sum   (ln_sum),
        .use_ln   (use_ln),
        .exp_tile (exp_tile)
    );

    sum_accumulator u_sum_accumulator (
        .clk       (clk),
        .rst_n     (rst_n),
        .sum_clear (sum_clear),
        .sum_en    (sum_en),
        .exp_tile  (exp_tile),
        .sum_exp   (sum_exp)
    );

    ln_unit u_ln_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .ln_load (ln_load),
        .sum_exp (sum_exp),
        .ln_sum  (ln_sum)
    );

endmodule

//--- sum_accumulator.sv
/*
 * Lane adder for one exp tile and the wide running exp sum
 */
`timescale 1ns/1ps
`include "softmax_defs.svh"

module sum_accumulator (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sum_clear,
    input  logic                        sum_en,
    input  logic [`SOFTMAX_TILE_W-1:0]  exp_tile,
    output logic [`SOFTMAX_SUM_W-1:0]   sum_exp
);

    localparam int W     = `SOFTMAX_WIDTH;
    localparam int TILE  = `SOFTMAX_TILE;
    localparam int SUM_W = `SOFTMAX_SUM_W;

    logic [SUM_W-1:0] tile_sum;

    // Exp values are never negative, so lanes zero-extend
    always_comb begin
        tile_sum = '0;
        for (int i = 0; i < TILE; i++) begin
            tile_sum = tile_sum + SUM_W'(exp_tile[(TILE-1-i)*W +: W]);
        end
    end

    // Cleared at the start of a run, one tile added per strobe
    always_ff @(posedge clk) begin
        if (!rst_n || sum_clear) begin
            sum_exp <= '0;
        end else if (sum_en) begin
            sum_exp <= sum_exp + tile_sum;
        end
    end

endmodule

//--- tb_softmax_vec.sv
/*
 * Table-driven testbench for the two-pass streaming softmax
 * Normalization, uniform, order, shift, protocol and back-to-back checks
 */
`timescale 1ns/1ps
`include "softmax_defs.svh"

module tb_softmax_vec;

    localparam int W       = `SOFTMAX_WIDTH;
    localparam int TILE    = `SOFTMAX_TILE;
    localparam int ELEMS   = `SOFTMAX_ELEMS;
    localparam int TILES   = `SOFTMAX_TILES;
    localparam int ONE     = 1 << `SOFTMAX_FRAC;
    localparam int VECS    = 5;
    localparam int MAX_GAP = 3;
    localparam int LIMIT   = VECS * (TILES * 2 + MAX_GAP * TILES + 40);
    // 100.0, far above any real element
    localparam logic [W-1:0] JUNK = 32'h0064_0000;

    localparam int K_UNIFORM = 0;
    localparam int K_RANDOM  = 1;
    localparam int K_SHIFTED = 2;
    localparam int K_B2B     = 3;
    localparam int K_ALONE   = 4;

    // Kind, base value and tolerance of the output sum, values in Q16.16
    // Random kinds spread 2.0 either side of the base
    // Shifted adds the base to the previous vector, alone replays it after a reset
    localparam int KIND [VECS] = '{K_UNIFORM, K_RANDOM, K_SHIFTED, K_B2B, K_ALONE};
    localparam int BASE [VECS] = '{-5 * ONE / 4, ONE / 2, 3 * ONE, -ONE, 0};
    localparam int TOL  [VECS] = '{ONE / 50, ONE / 10, ONE / 10, ONE / 10, ONE / 10};

    logic                        clk;
    logic                        rst_n;
    logic                        start;
    logic [`SOFTMAX_TILE_W-1:0]  x_tile;
    logic                        tile_in_valid;
    logic [`SOFTMAX_TILE_W-1:0]  y_tile;
    logic                        tile_out_valid;
    logic                        done;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic started = 1'b0;
    logic done_d = 1'b0;

    // Current vector and the one before it
    int vec_in [ELEMS];
    int vec_out [ELEMS];
    int prev_in [ELEMS];
    int prev_out [ELEMS];

    softmax_vec u_softmax_vec (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .x_tile         (x_tile),
        .tile_in_valid  (tile_in_valid),
        .y_tile         (y_tile),
        .tile_out_valid (tile_out_valid),
        .done           (done)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic verify(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERR %0t: %s", $time, what);
        end
    endtask

    // Start is stable at the rising edge
    always @(posedge clk) begin
        if (start) begin
            started <= 1'b1;
        end
    end

    // Strobe rules and run limit, sampled mid-cycle
    always @(negedge clk) begin
        cycles++;
        if (!started) begin
            verify(!tile_out_valid && !done, "output strobe before the first start");
        end
        verify(!(done && done_d), "done high for more than one cycle");
        done_d = done;
        if (cycles >= LIMIT) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display("tests failed");
            $finish;
        end
    end

    task automatic hold_reset();
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic build_vector(input int v);
        for (int i = 0; i < ELEMS; i++) begin
            case (KIND[v])
                K_UNIFORM: vec_in[i] = BASE[v];
                K_SHIFTED: vec_in[i] = prev_in[i] + BASE[v];
                K_ALONE:   vec_in[i] = prev_in[i];
                default:   vec_in[i] = BASE[v] - 2 * ONE + int'($urandom % (4 * ONE));
            endcase
        end
    endtask

    // Junk tile rides along with start and must be dropped
    task automatic pulse_start(input bit in_done_cycle);
        if (!in_done_cycle) begin
            @(negedge clk);
        end
        start         = 1'b1;
        tile_in_valid = 1'b1;
        x_tile        = {TILE{JUNK}};
        @(negedge clk);
        start         = 1'b0;
        tile_in_valid = 1'b0;
    endtask

    task automatic send_tiles();
        int gap;
        for (int t = 0; t < TILES; t++) begin
            gap = ($urandom % 3 == 0) ? int'(1 + $urandom % MAX_GAP) : 0;
            tile_in_valid = 1'b0;
            repeat (gap) @(negedge clk);
            // Element 0 in the top chunk
            for (int l = 0; l < TILE; l++) begin
                x_tile[(TILE-1-l)*W +: W] = vec_in[t*TILE + l];
            end
            tile_in_valid = 1'b1;
            @(negedge clk);
        end
        tile_in_valid = 1'b0;
    endtask

    // Junk keeps coming for three cycles after the load phase
    task automatic collect_outputs();
        int n_valid;
        int iter;
        bit prev_valid;
        bit finished;
        n_valid    = 0;
        iter       = 0;
        prev_valid = 1'b0;
        finished   = 1'b0;
        x_tile     = {TILE{JUNK}};
        while (!finished) begin
            tile_in_valid = (iter < 3);
            @(negedge clk);
            iter++;
            if (tile_out_valid) begin
                verify(n_valid == 0 || prev_valid, "gap inside the output burst");
                verify(n_valid < TILES, "more output tiles than input tiles");
                if (n_valid < TILES) begin
                    for (int l = 0; l < TILE; l++) begin
                        vec_out[n_valid*TILE + l] = int'(y_tile[(TILE-1-l)*W +: W]);
                    end
                end
                n_valid++;
            end
            if (done) begin
                finished = 1'b1;
                verify(prev_valid && !tile_out_valid, "done not right after the last output");
                verify(n_valid == TILES,
                       $sformatf("%0d output tiles, expected %0d", n_valid, TILES));
            end
            prev_valid = tile_out_valid;
        end
        tile_in_valid = 1'b0;
    endtask

    task automatic check_vector(input int v);
        int total;
        int amax;
        total = 0;
        amax  = 0;
        for (int i = 0; i < ELEMS; i++) begin
            total += vec_out[i];
            verify(vec_out[i] >= 0, $sformatf("vector %0d element %0d negative", v, i));
            if (vec_in[i] > vec_in[amax]) begin
                amax = i;
            end
        end
        // exp(a - ln s) ~ exp(a) / s, so outputs add up to about 1.0
        verify(total >= ONE - TOL[v] && total <= ONE + TOL[v],
               $sformatf("vector %0d sums to 0x%08h", v, total));
        for (int i = 0; i < ELEMS; i++) begin
            if (KIND[v] == K_UNIFORM) begin
                verify(vec_out[i] == vec_out[0], $sformatf("uniform element %0d differs", i));
                verify(vec_out[i] >= ONE / ELEMS - TOL[v] / ELEMS &&
                       vec_out[i] <= ONE / ELEMS + TOL[v] / ELEMS,
                       $sformatf("uniform element %0d is 0x%08h", i, vec_out[i]));
            end else begin
                verify(vec_out[amax] >= vec_out[i],
                       $sformatf("vector %0d largest input %0d not largest output", v, amax));
                for (int j = 0; j < ELEMS; j++) begin
                    verify(vec_in[i] <= vec_in[j] || vec_out[i] >= vec_out[j],
                           $sformatf("vector %0d order broken at %0d and %0d", v, i, j));
                end
            end
            // Same result as the earlier run
            if (KIND[v] == K_SHIFTED || KIND[v] == K_ALONE) begin
                verify(vec_out[i] == prev_out[i],
                       $sformatf("vector %0d element %0d 0x%08h, earlier run 0x%08h",
                                 v, i, vec_out[i], prev_out[i]));
            end
        end
    endtask

    initial begin
        void'($urandom(91));
        start         = 1'b0;
        tile_in_valid = 1'b0;
        x_tile        = '0;
        hold_reset();
        for (int v = 0; v < VECS; v++) begin
            build_vector(v);
            if (KIND[v] == K_ALONE) begin
                hold_reset();
            end
            // Back-to-back start lands in the done cycle
            pulse_start(KIND[v] == K_B2B);
            send_tiles();
            collect_outputs();
            check_vector(v);
            prev_in  = vec_in;
            prev_out = vec_out;
        end
        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tile_buffer.sv
/*
 * Tile RAM with one write port and one registered read port
 */
`timescale 1ns/1ps
`include "softmax_defs.svh"

module tile_buffer (
    input  logic                        clk,
    input  logic                        wr_en,
    input  logic [`SOFTMAX_ADDR_W-1:0]  wr_addr,
    input  logic [`SOFTMAX_TILE_W-1:0]  wr_tile,
    input  logic [`SOFTMAX_ADDR_W-1:0]  rd_addr,
    output logic [`SOFTMAX_TILE_W-1:0]  rd_tile
);

    // One entry per tile of the vector
    logic [`SOFTMAX_TILE_W-1:0] mem [`SOFTMAX_TILES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_tile;
        end
        // Read data valid one cycle after the address
        rd_tile <= mem[rd_addr];
    end

endmodule
